/* build.f */
+incdir+include
rtl/jpeg_coeff_pkg.sv
rtl/jpeg_sym_pkg.sv
rtl/rle_scanner.sv
rtl/coeff_fetch.sv
rtl/symbol_former.sv
rtl/jpeg_rle_encoder.sv
tests/tb_clock.sv
tests/tb_jpeg_rle_encoder.sv

/* tests/tb_jpeg_rle_encoder.sv */
//**************************************************************************
// Testbench of the JPEG run-length and VLI front end.
// Random blocks through a coefficient buffer model, symbols checked
// against a reference model of the run-length and VLI rules.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_jpeg_rle_encoder;
	import jpeg_coeff_pkg::*;
	import jpeg_sym_pkg::*;

	localparam int NUM_BLOCKS = 40;
	localparam int GO_GAP     = 70;
	localparam int DC_LATENCY = 4;
	localparam int LIMIT_NS   = NUM_BLOCKS * 80 * 4 + 200;

	typedef struct packed {
		vli_sym_t sym;
		logic     last;
	} exp_sym_t;

	logic     clk;
	logic     arst_n;
	logic     blk_go;
	blk_cmd_t cmd;
	zz_idx_t  coeff_addr;
	logic     coeff_rd;
	coeff_t   coeff_data = '0;
	logic     sym_valid;
	vli_sym_t sym;
	logic     blk_done;

	integer   seed;
	coeff_t   buf_mem [BLK_SIZE];
	// current block, natural order
	coeff_t   blk [BLK_SIZE];
	int       prev_dc;
	exp_sym_t exp_q [$];
	int       cycle = 0;
	int       go_cycle = 0;
	int       done_count = 0;
	int       sym_count = 0;
	int       rd_count = 0;

	tb_clock i_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	jpeg_rle_encoder i_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.blk_go     (blk_go),
		.cmd        (cmd),
		.coeff_addr (coeff_addr),
		.coeff_rd   (coeff_rd),
		.coeff_data (coeff_data),
		.sym_valid  (sym_valid),
		.sym        (sym),
		.blk_done   (blk_done)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, got, exp));
		end
	endtask

	function automatic int bit_length(input int v);
		int mag;
		int n;
		mag = (v < 0) ? -v : v;
		n   = 0;
		while (mag != 0) begin
			mag = mag >> 1;
			n++;
		end
		return n;
	endfunction

	// negative amplitude is the complement of the magnitude
	function automatic int vli_amp(input int v, input int size);
		if (v < 0) begin
			return (1 << size) - 1 + v;
		end
		return v;
	endfunction

	function automatic int zz_coeff(input int k);
		return blk[dezigzag(ZZ_W'(k))];
	endfunction

	function automatic logic [BLK_SIZE-1:0] zz_mask();
		logic [BLK_SIZE-1:0] m;
		for (int k = 0; k < BLK_SIZE; k++) begin
			m[k] = (zz_coeff(k) != 0);
		end
		return m;
	endfunction

	function automatic int random_coeff();
		int sz;
		int mag;
		sz  = 1 + $unsigned($random(seed)) % 11;
		mag = 1 + $unsigned($random(seed)) % ((1 << sz) - 1);
		return ($random(seed) & 1) ? -mag : mag;
	endfunction

	task automatic push_sym(input ev_kind_t kind, input int run, input int v,
			input logic last);
		exp_sym_t e;
		int       sz;
		sz         = bit_length(v);
		e.sym.kind = kind;
		e.sym.run  = RUN_W'(run);
		e.sym.size = SIZE_W'(sz);
		e.sym.amp  = AMP_W'(vli_amp(v, sz));
		e.last     = last;
		exp_q.push_back(e);
	endtask

	// blocks 0 to 3 are fixed edge cases, the rest random density
	task automatic make_block(input int b);
		int   density;
		logic nz;
		density = $unsigned($random(seed)) % 101;
		for (int k = 0; k < BLK_SIZE; k++) begin
			case (b)
				0:       nz = (k == 0);
				1:       nz = 1'b1;
				2:       nz = (k == 0 || k == BLK_SIZE - 1);
				3:       nz = (k == 17 || k == 50);
				default: nz = ($unsigned($random(seed)) % 100) < density;
			endcase
			blk[dezigzag(ZZ_W'(k))] = nz ? coeff_t'(random_coeff()) : '0;
		end
		// full-scale AC values of both signs
		if (b == 1) begin
			blk[dezigzag(ZZ_W'(1))] = coeff_t'(2047);
			blk[dezigzag(ZZ_W'(2))] = coeff_t'(-2047);
		end
	endtask

	task automatic model_block(input logic restart);
		int   dc;
		int   zeros;
		logic ended;
		logic rest_nz;
		dc = zz_coeff(0);
		push_sym(EV_DC, 0, restart ? dc : dc - prev_dc, 1'b0);
		prev_dc = dc;
		zeros   = 0;
		ended   = 1'b0;
		for (int k = 1; k < BLK_SIZE && !ended; k++) begin
			rest_nz = 1'b0;
			for (int j = k; j < BLK_SIZE; j++) begin
				rest_nz = rest_nz | (zz_coeff(j) != 0);
			end
			if (!rest_nz) begin
				push_sym(EV_EOB, 0, 0, 1'b1);
				ended = 1'b1;
			end else if (zz_coeff(k) != 0) begin
				push_sym(EV_AC, zeros, zz_coeff(k), k == BLK_SIZE - 1);
				zeros = 0;
			end else if (zeros == 15) begin
				push_sym(EV_ZRL, 15, 0, 1'b0);
				zeros = 0;
			end else begin
				zeros++;
			end
		end
	endtask

	// synchronous read buffer
	always @(posedge clk) begin
		if (coeff_rd) begin
			coeff_data <= buf_mem[coeff_addr];
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	always @(negedge clk) begin : monitor
		exp_sym_t e;
		if (arst_n) begin
			if (blk_go) begin
				go_cycle = cycle;
			end
			if (coeff_rd) begin
				// read of position k comes k+1 cycles after the go
				check_value("coeff_addr", coeff_addr,
					dezigzag(ZZ_W'(cycle - go_cycle - 1)));
				rd_count++;
			end
			if (sym_valid && exp_q.size() == 0) begin
				abort_run("a symbol came out when none was expected");
			end else if (sym_valid) begin
				e = exp_q.pop_front();
				if (e.sym.kind == EV_DC) begin
					check_value("dc latency", cycle - go_cycle, DC_LATENCY);
				end
				check_value("sym.kind", sym.kind, e.sym.kind);
				check_value("sym.run", sym.run, e.sym.run);
				check_value("sym.size", sym.size, e.sym.size);
				check_value("sym.amp", sym.amp, e.sym.amp);
				check_value("blk_done", blk_done, e.last);
				sym_count++;
				if (blk_done) begin
					done_count++;
				end
			end else begin
				check_value("blk_done", blk_done, 1'b0);
			end
		end
	end

	initial begin : stimulus
		int   waited;
		int   gap;
		int   done_seen;
		logic restart;
		seed    = 57;
		prev_dc = 0;
		blk_go  = 1'b0;
		cmd     = '0;
		wait (arst_n === 1'b1);
		repeat (2) @(posedge clk);
		for (int b = 0; b < NUM_BLOCKS; b++) begin
			make_block(b);
			restart = (b == 0) || (($random(seed) & 3) == 0);
			model_block(restart);
			done_seen = done_count;
			@(posedge clk);
			for (int k = 0; k < BLK_SIZE; k++) begin
				buf_mem[k] <= blk[k];
			end
			cmd.nz_mask    <= zz_mask();
			cmd.restart_dc <= restart;
			blk_go         <= 1'b1;
			@(posedge clk);
			blk_go <= 1'b0;
			waited = 1;
			while (done_count == done_seen) begin
				@(posedge clk);
				waited++;
			end
			// fetch must finish before the next go
			gap = GO_GAP + $unsigned($random(seed)) % 6;
			while (waited < gap) begin
				@(posedge clk);
				waited++;
			end
			// every block reads all 64 coefficients once
			check_value("coeff_rd count", rd_count, (b + 1) * BLK_SIZE);
		end
		repeat (8) @(posedge clk);
		if (exp_q.size() == 0 && sym_count > 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			abort_run($sformatf("%0d expected symbols never came out", exp_q.size()));
		end
	end

	initial begin : watchdog
		#(LIMIT_NS);
		abort_run($sformatf("time-out: the run did not finish within %0d ns", LIMIT_NS));
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
//**************************************************************************
// Testbench clock and reset.
// 4 ns clock, reset held low for the first 8 cycles.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk,
	output logic arst_n
);
	localparam int HALF_NS    = 2;
	localparam int RST_CYCLES = 8;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/jpeg_rle_encoder.sv */
//**************************************************************************
// JPEG run-length and VLI front end, top level.
// Scanner and coefficient fetch run side by side on each block, the
// symbol former merges them into one symbol stream.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module jpeg_rle_encoder (
	input  wire                             clk,
	input  wire                             arst_n,
	input  wire                             blk_go,
	input  wire jpeg_sym_pkg::blk_cmd_t     cmd,
	output jpeg_coeff_pkg::zz_idx_t         coeff_addr,
	output logic                            coeff_rd,
	input  wire jpeg_coeff_pkg::coeff_t     coeff_data,
	output logic                            sym_valid,
	output jpeg_sym_pkg::vli_sym_t          sym,
	output logic                            blk_done
);
	import jpeg_coeff_pkg::*;
	import jpeg_sym_pkg::*;

	logic       ev_valid;
	rle_event_t ev;
	logic       val_valid;
	diff_t      val;

	rle_scanner i_scanner (
		.clk      (clk),
		.arst_n   (arst_n),
		.blk_go   (blk_go),
		.nz_mask  (cmd.nz_mask),
		.ev_valid (ev_valid),
		.ev       (ev)
	);

	coeff_fetch i_fetch (
		.clk        (clk),
		.arst_n     (arst_n),
		.blk_go     (blk_go),
		.restart_dc (cmd.restart_dc),
		.coeff_addr (coeff_addr),
		.coeff_rd   (coeff_rd),
		.coeff_data (coeff_data),
		.val_valid  (val_valid),
		.val        (val)
	);

	// symbols trail blk_go by 4 cycles
	symbol_former i_former (
		.clk       (clk),
		.arst_n    (arst_n),
		.ev_valid  (ev_valid),
		.ev        (ev),
		.val_valid (val_valid),
		.val       (val),
		.sym_valid (sym_valid),
		.sym       (sym),
		.blk_done  (blk_done)
	);

endmodule

`default_nettype wire

/* rtl/symbol_former.sv */
//**************************************************************************
// VLI symbol former.
// Joins each scanner event with its coefficient value and forms the
// run, VLI size and VLI amplitude of the symbol.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module symbol_former (
	input  wire                             clk,
	input  wire                             arst_n,
	input  wire                             ev_valid,
	input  wire jpeg_sym_pkg::rle_event_t   ev,
	input  wire                             val_valid,
	input  wire jpeg_coeff_pkg::diff_t      val,
	output logic                            sym_valid,
	output jpeg_sym_pkg::vli_sym_t          sym,
	output logic                            blk_done
);
	import jpeg_coeff_pkg::*;
	import jpeg_sym_pkg::*;

	logic              ev_vld_d1;
	logic              ev_vld_d2;
	rle_event_t        ev_d1;
	rle_event_t        ev_d2;
	logic              join_ok;
	diff_t             amp_raw;
	logic [AMP_W-1:0]  amp_mask;
	vli_sym_t          sym_nxt;

	// bit length of the magnitude
	function automatic logic [SIZE_W-1:0] vli_size(input diff_t v);
		logic [DIFF_W-1:0] mag;
		logic [SIZE_W-1:0] n;
		mag = (v < 0) ? DIFF_W'(-v) : DIFF_W'(v);
		n   = '0;
		for (int i = 0; i < DIFF_W; i++) begin
			if (mag[i]) begin
				n = SIZE_W'(i + 1);
			end
		end
		return n;
	endfunction

	// event two cycles behind meets its value
	assign join_ok = ev_vld_d2 && val_valid;

	always_comb begin
		sym_nxt.kind = ev_d2.kind;
		sym_nxt.run  = ev_d2.run;
		sym_nxt.size = vli_size(val);
		// negative values are sent as ones' complement
		amp_raw      = (val < 0) ? val - diff_t'(1) : val;
		amp_mask     = ~({AMP_W{1'b1}} << sym_nxt.size);
		sym_nxt.amp  = amp_raw[AMP_W-1:0] & amp_mask;
		if (ev_d2.kind == EV_ZRL) begin
			sym_nxt.run  = ZRL_RUN;
			sym_nxt.size = '0;
			sym_nxt.amp  = '0;
		end else if (ev_d2.kind == EV_EOB) begin
			sym_nxt.run  = '0;
			sym_nxt.size = '0;
			sym_nxt.amp  = '0;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ev_vld_d1 <= 1'b0;
			ev_vld_d2 <= 1'b0;
			sym_valid <= 1'b0;
			blk_done  <= 1'b0;
		end else begin
			ev_vld_d1 <= ev_valid;
			ev_vld_d2 <= ev_vld_d1;
			sym_valid <= join_ok;
			blk_done  <= join_ok && ev_d2.last;
		end
	end

	always_ff @(posedge clk) begin
		ev_d1 <= ev;
		ev_d2 <= ev_d1;
		sym   <= sym_nxt;
	end

endmodule

`default_nettype wire

/* rtl/coeff_fetch.sv */
//**************************************************************************
// Coefficient fetch with DC prediction.
// Reads all 64 coefficients of a block in zigzag order from the
// synchronous coefficient buffer and subtracts the DC predictor.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module coeff_fetch (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire                      blk_go,
	input  wire                      restart_dc,
	output jpeg_coeff_pkg::zz_idx_t  coeff_addr,
	output logic                     coeff_rd,
	input  wire jpeg_coeff_pkg::coeff_t coeff_data,
	output logic                     val_valid,
	output jpeg_coeff_pkg::diff_t    val
);
	import jpeg_coeff_pkg::*;

	zz_idx_t zz;
	zz_idx_t zz_nxt;
	logic    rd_d1;
	logic    dc_d1;
	logic    restart;
	coeff_t  pred;
	diff_t   dc_base;

	// a new go restarts the walk at position 0
	assign zz_nxt  = blk_go ? '0 : zz + 1'b1;
	assign dc_base = restart ? '0 : diff_t'(pred);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			coeff_rd <= 1'b0;
			zz       <= '0;
			restart  <= 1'b0;
		end else if (blk_go) begin
			coeff_rd <= 1'b1;
			zz       <= '0;
			restart  <= restart_dc;
		end else if (coeff_rd) begin
			coeff_rd <= (zz != ZZ_W'(BLK_SIZE - 1));
			zz       <= zz_nxt;
		end
	end

	// address leaves in step with the read strobe
	always_ff @(posedge clk) begin
		if (blk_go || coeff_rd) begin
			coeff_addr <= dezigzag(zz_nxt);
		end
	end

	// buffer answers one cycle after the strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_d1     <= 1'b0;
			dc_d1     <= 1'b0;
			val_valid <= 1'b0;
			pred      <= '0;
		end else begin
			rd_d1     <= coeff_rd;
			dc_d1     <= coeff_rd && (zz == '0);
			val_valid <= rd_d1;
			if (dc_d1) begin
				pred <= coeff_data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dc_d1) begin
			val <= diff_t'(coeff_data) - dc_base;
		end else begin
			val <= diff_t'(coeff_data);
		end
	end

endmodule

`default_nettype wire

/* rtl/rle_scanner.sv */
//**************************************************************************
// Run-length scanner.
// Walks the nonzero mask in zigzag order, one position per clock, and
// forms the DC, AC, ZRL and EOB events of one block.
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module rle_scanner (
	input  wire                                 clk,
	input  wire                                 arst_n,
	input  wire                                 blk_go,
	input  wire [jpeg_coeff_pkg::BLK_SIZE-1:0]  nz_mask,
	output logic                                ev_valid,
	output jpeg_sym_pkg::rle_event_t            ev
);
	import jpeg_coeff_pkg::*;
	import jpeg_sym_pkg::*;

	logic                busy;
	logic                start;
	zz_idx_t             pos;
	logic [RUN_W-1:0]    zrun;
	logic [RUN_W-1:0]    zrun_nxt;
	// bit 0 is the current position, higher bits the rest of the block
	logic [BLK_SIZE-1:0] mask_sh;
	logic                rest_zero;
	logic                emit;
	rle_event_t          ev_nxt;

	// a go while busy is dropped
	assign start     = blk_go && !busy;
	assign rest_zero = (mask_sh == '0);

	always_comb begin
		emit        = 1'b0;
		zrun_nxt    = zrun;
		ev_nxt.kind = EV_AC;
		ev_nxt.run  = zrun;
		if (rest_zero) begin
			emit        = 1'b1;
			ev_nxt.kind = EV_EOB;
		end else if (mask_sh[0]) begin
			emit     = 1'b1;
			zrun_nxt = '0;
		end else if (zrun == ZRL_RUN) begin
			// 16th zero in a row, a nonzero still follows
			emit        = 1'b1;
			ev_nxt.kind = EV_ZRL;
			zrun_nxt    = '0;
		end else begin
			zrun_nxt = zrun + 1'b1;
		end
		ev_nxt.last = emit && (ev_nxt.kind == EV_EOB || pos == ZZ_W'(BLK_SIZE - 1));
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy     <= 1'b0;
			pos      <= '0;
			zrun     <= '0;
			ev_valid <= 1'b0;
		end else if (start) begin
			// position 0 goes out as DC right away
			busy     <= 1'b1;
			pos      <= ZZ_W'(1);
			zrun     <= '0;
			ev_valid <= 1'b1;
		end else if (busy) begin
			pos      <= pos + 1'b1;
			zrun     <= zrun_nxt;
			ev_valid <= emit;
			if (ev_nxt.last) begin
				busy <= 1'b0;
			end
		end else begin
			ev_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mask_sh <= nz_mask >> 1;
			ev      <= '{kind: EV_DC, run: '0, last: 1'b0};
		end else if (busy) begin
			mask_sh <= mask_sh >> 1;
			ev      <= ev_nxt;
		end
	end

endmodule

`default_nettype wire

/* rtl/jpeg_sym_pkg.sv */
//**************************************************************************
// JPEG run-length symbol definitions.
// Event kinds, scanner events, VLI symbols and the per-block command.
//**************************************************************************
`default_nettype none

package jpeg_sym_pkg;

	localparam int SIZE_W = 4;
	localparam int RUN_W  = 4;
	localparam int AMP_W  = 12;

	// run carried by a zero-run-length symbol (16 zeros)
	localparam logic [RUN_W-1:0] ZRL_RUN = 4'd15;

	typedef enum logic [1:0] {
		EV_DC  = 2'd0,
		EV_AC  = 2'd1,
		EV_ZRL = 2'd2,
		EV_EOB = 2'd3
	} ev_kind_t;

	// one scanner event, last marks the final event of a block
	typedef struct packed {
		ev_kind_t         kind;
		logic [RUN_W-1:0] run;
		logic             last;
	} rle_event_t;

	typedef struct packed {
		ev_kind_t          kind;
		logic [RUN_W-1:0]  run;
		logic [SIZE_W-1:0] size;
		logic [AMP_W-1:0]  amp;
	} vli_sym_t;

	// bit k of the mask is zigzag position k
	typedef struct packed {
		logic [jpeg_coeff_pkg::BLK_SIZE-1:0] nz_mask;
		logic                                restart_dc;
	} blk_cmd_t;

endpackage

`default_nettype wire

/* rtl/jpeg_coeff_pkg.sv */
//**************************************************************************
// JPEG coefficient definitions.
// Widths of quantized coefficients and DC differences, block size and
// the zigzag to natural-order lookup.
//**************************************************************************
`default_nettype none

package jpeg_coeff_pkg;

	localparam int BLK_SIZE = 64;
	localparam int ZZ_W     = 6;
	localparam int COEFF_W  = 12;
	// one bit more than a coefficient, holds any DC difference
	localparam int DIFF_W   = 13;

	typedef logic signed [COEFF_W-1:0] coeff_t;
	typedef logic signed [DIFF_W-1:0]  diff_t;
	typedef logic [ZZ_W-1:0]           zz_idx_t;

	`include "zigzag_table.svh"

	// zigzag position to buffer address
	function automatic zz_idx_t dezigzag(input zz_idx_t zz);
		return ZIGZAG_TABLE[zz];
	endfunction

endpackage

`default_nettype wire

/* include/zigzag_table.svh */
//**************************************************************************
// Zigzag scan table of the JPEG block.
// Entry k gives the natural-order buffer index of zigzag position k.
// The buffer is stored column-major, so index = col * 8 + row.
//**************************************************************************
`ifndef ZIGZAG_TABLE_SVH
`define ZIGZAG_TABLE_SVH

localparam zz_idx_t ZIGZAG_TABLE [BLK_SIZE] = '{
	6'd0,
	6'd8,
	6'd1,
	6'd2,
	6'd9,
	6'd16,
	6'd24,
	6'd17,
	6'd10,
	6'd3,
	6'd4,
	6'd11,
	6'd18,
	6'd25,
	6'd32,
	6'd40,
	6'd33,
	6'd26,
	6'd19,
	6'd12,
	6'd5,
	6'd6,
	6'd13,
	6'd20,
	6'd27,
	6'd34,
	6'd41,
	6'd48,
	6'd56,
	6'd49,
	6'd42,
	6'd35,
	6'd28,
	6'd21,
	6'd14,
	6'd7,
	6'd15,
	6'd22,
	6'd29,
	6'd36,
	6'd43,
	6'd50,
	6'd57,
	6'd58,
	6'd51,
	6'd44,
	6'd37,
	6'd30,
	6'd23,
	6'd31,
	6'd38,
	6'd45,
	6'd52,
	6'd59,
	6'd60,
	6'd53,
	6'd46,
	6'd39,
	6'd47,
	6'd54,
	6'd61,
	6'd62,
	6'd55,
	6'd63
};

`endif
